// File: rtl/axil_pkg.sv
package axil_pkg;

    localparam int axil_addr_w = 32;
    localparam int axil_data_w = 32;

    // response code returned by the memory
    localparam logic [1:0] axil_resp_okay = 2'b00;

    typedef struct packed {
        logic [axil_addr_w-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [axil_data_w-1:0]   data;
        logic [axil_data_w/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [axil_addr_w-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [axil_data_w-1:0] data;
        logic [1:0]             resp;
    } axil_r_t;

    // master side of one link
    typedef struct packed {
        axil_aw_t aw;
        logic     awvalid;
        axil_w_t  w;
        logic     wvalid;
        axil_ar_t ar;
        logic     arvalid;
        logic     bready;
        logic     rready;
    } axil_req_t;

    // slave side of one link
    typedef struct packed {
        logic    awready;
        logic    wready;
        logic    arready;
        axil_b_t b;
        logic    bvalid;
        axil_r_t r;
        logic    rvalid;
    } axil_rsp_t;

endpackage

// File: rtl/lsu_pkg.sv
package lsu_pkg;

    // major opcodes
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // funct3 width and sign codes
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    // I-type layout
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } load_fmt_t;

    // S-type layout, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } store_fmt_t;

    typedef union packed {
        load_fmt_t  ld;
        store_fmt_t st;
    } mem_inst_t;

    typedef struct packed {
        mem_inst_t   inst;
        logic [31:0] base;
        logic [31:0] store_data;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        load;
        logic        err;
    } lsu_resp_t;

endpackage

// File: rtl/lsu_port.sv
`timescale 1ns/100ps

module lsu_port import axil_pkg::*, lsu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      req_valid,
    output logic      req_ready,
    input  lsu_req_t  req,
    output logic      resp_valid,
    output lsu_resp_t resp,
    output axil_req_t bus_req,
    input  axil_rsp_t bus_rsp
);

    typedef enum logic [1:0] {st_idle, st_addr, st_wait, st_resp} state_t;

    state_t      state;
    mem_inst_t   inst;
    logic        is_load;
    logic        is_store;
    logic [2:0]  f3;
    logic [31:0] imm;
    logic [31:0] addr;
    logic        f3_ok;
    logic        misaligned;
    logic        err;
    logic        accept;
    logic [3:0]  strb;

    logic        arvalid_q;
    logic        awvalid_q;
    logic        wvalid_q;
    logic        ar_left;
    logic        aw_left;
    logic        w_left;

    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  strb_q;
    logic [1:0]  off_q;
    logic [2:0]  f3_q;
    logic        ld_q;
    logic        err_q;
    logic [31:0] rdata_q;

    // pick the addressed lane and extend it
    function automatic logic [31:0] extend(input logic [31:0] word, input logic [1:0] off,
                                           input logic [2:0] fn);
        logic [31:0] sh;
        sh = word >> {off, 3'b000};
        case (fn)
            f3_b:    return {{24{sh[7]}}, sh[7:0]};
            f3_h:    return {{16{sh[15]}}, sh[15:0]};
            f3_bu:   return {24'b0, sh[7:0]};
            f3_hu:   return {16'b0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    assign inst     = req.inst;
    assign is_load  = inst.ld.opcode == op_load;
    assign is_store = inst.st.opcode == op_store;
    assign f3       = inst.ld.funct3;

    // same word, two immediate layouts
    assign imm  = is_store ? {{20{inst.st.imm_hi[6]}}, inst.st.imm_hi, inst.st.imm_lo}
                           : {{20{inst.ld.imm[11]}}, inst.ld.imm};
    assign addr = req.base + imm;

    always_comb begin
        f3_ok = (f3 == f3_b) || (f3 == f3_h) || (f3 == f3_w);
        if (is_load && (f3 == f3_bu || f3 == f3_hu)) begin
            f3_ok = 1'b1;
        end
        misaligned = ((f3 == f3_h || f3 == f3_hu) && addr[0]) ||
                     ((f3 == f3_w) && (addr[1:0] != 2'b00));
        err = !(is_load || is_store) || !f3_ok || misaligned;
        case (f3)
            f3_b:    strb = 4'b0001 << addr[1:0];
            f3_h:    strb = 4'b0011 << addr[1:0];
            default: strb = 4'b1111;
        endcase
    end

    assign req_ready = state == st_idle;
    assign accept    = req_valid && req_ready;

    // valids still waiting for their ready
    assign ar_left = arvalid_q && !bus_rsp.arready;
    assign aw_left = awvalid_q && !bus_rsp.awready;
    assign w_left  = wvalid_q && !bus_rsp.wready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            arvalid_q <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && err) begin
                        state <= st_resp;
                    end else if (accept) begin
                        state     <= st_addr;
                        arvalid_q <= is_load;
                        awvalid_q <= is_store;
                        wvalid_q  <= is_store;
                    end
                end
                st_addr: begin
                    arvalid_q <= ar_left;
                    awvalid_q <= aw_left;
                    wvalid_q  <= w_left;
                    if (!(ar_left || aw_left || w_left)) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    // ready is held high, so valid alone completes it
                    if (bus_rsp.rvalid || bus_rsp.bvalid) begin
                        state <= st_resp;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= addr;
            wdata_q <= req.store_data << {addr[1:0], 3'b000};
            strb_q  <= strb;
            off_q   <= addr[1:0];
            f3_q    <= f3;
            ld_q    <= is_load;
            err_q   <= err;
            rdata_q <= '0;
        end
        if (state == st_wait && bus_rsp.rvalid) begin
            rdata_q <= extend(bus_rsp.r.data, off_q, f3_q);
            err_q   <= bus_rsp.r.resp[1];
        end
        if (state == st_wait && bus_rsp.bvalid) begin
            err_q <= bus_rsp.b.resp[1];
        end
    end

    assign resp_valid = state == st_resp;
    assign resp.data  = rdata_q;
    assign resp.load  = ld_q;
    assign resp.err   = err_q;

    always_comb begin
        bus_req         = '0;
        bus_req.aw.addr = addr_q;
        bus_req.ar.addr = addr_q;
        bus_req.w.data  = wdata_q;
        bus_req.w.strb  = strb_q;
        bus_req.arvalid = arvalid_q;
        bus_req.awvalid = awvalid_q;
        bus_req.wvalid  = wvalid_q;
        bus_req.bready  = 1'b1;
        bus_req.rready  = 1'b1;
    end

endmodule

// File: rtl/axil_arbiter.sv
`timescale 1ns/100ps

module axil_arbiter import axil_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  axil_req_t m_req [2],
    output axil_rsp_t m_rsp [2],
    output axil_req_t s_req,
    input  axil_rsp_t s_rsp
);

    logic       busy;
    logic       grant;
    logic       last;
    logic [1:0] want;
    logic       pick;
    logic       done;

    // any address or data valid counts as a request
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            want[i] = m_req[i].arvalid | m_req[i].awvalid | m_req[i].wvalid;
        end
    end

    // round robin, favour the master not served last
    always_comb begin
        if (want == 2'b11) begin
            pick = ~last;
        end else begin
            pick = want[1];
        end
    end

    // last response handshake of the open transaction
    assign done = (s_rsp.bvalid && s_req.bready) || (s_rsp.rvalid && s_req.rready);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            grant <= 1'b0;
            last  <= 1'b1;
        end else if (!busy) begin
            if (|want) begin
                busy  <= 1'b1;
                grant <= pick;
                last  <= pick;
            end
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // forwarding follows the grant combinationally
    always_comb begin
        if (busy) begin
            s_req = m_req[grant];
        end else begin
            s_req = '0;
        end
        for (int i = 0; i < 2; i++) begin
            if (busy && grant == 1'(i)) begin
                m_rsp[i] = s_rsp;
            end else begin
                // losing master sees no readies and no responses
                m_rsp[i] = '0;
            end
        end
    end

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/100ps

module data_mem import axil_pkg::*; #(
    parameter int mem_words = 1024
) (
    input  logic      clk,
    input  logic      reset,
    input  axil_req_t bus_req,
    output axil_rsp_t bus_rsp
);

    localparam int idx_w = $clog2(mem_words);

    logic [axil_data_w-1:0] mem [mem_words];
    logic [axil_data_w-1:0] rdata;
    logic                   rvalid;
    logic                   bvalid;
    logic                   wr_ok;
    logic                   rd_go;
    logic [idx_w-1:0]       rd_idx;
    logic [idx_w-1:0]       wr_idx;

    // word index, upper address bits wrap
    assign rd_idx = bus_req.ar.addr[idx_w+1:2];
    assign wr_idx = bus_req.aw.addr[idx_w+1:2];

    // address and data accepted in the same cycle
    assign wr_ok = bus_req.awvalid && bus_req.wvalid && !bvalid;
    assign rd_go = bus_req.arvalid && !rvalid;

    always_comb begin
        bus_rsp         = '0;
        bus_rsp.arready = !rvalid;
        bus_rsp.awready = wr_ok;
        bus_rsp.wready  = wr_ok;
        bus_rsp.b.resp  = axil_resp_okay;
        bus_rsp.bvalid  = bvalid;
        bus_rsp.r.data  = rdata;
        bus_rsp.r.resp  = axil_resp_okay;
        bus_rsp.rvalid  = rvalid;
    end

    // response flags held until the master takes them
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (rd_go) begin
                rvalid <= 1'b1;
            end else if (bus_req.rready) begin
                rvalid <= 1'b0;
            end
            if (wr_ok) begin
                bvalid <= 1'b1;
            end else if (bus_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            rdata <= mem[rd_idx];
        end
        if (wr_ok) begin
            for (int b = 0; b < axil_data_w / 8; b++) begin
                if (bus_req.w.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= bus_req.w.data[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: rtl/lsu_subsystem_top.sv
`timescale 1ns/100ps

module lsu_subsystem_top import axil_pkg::*, lsu_pkg::*; #(
    parameter int mem_words = 1024
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] req_valid,
    output logic [1:0] req_ready,
    input  lsu_req_t   req [2],
    output logic [1:0] resp_valid,
    output lsu_resp_t  resp [2]
);

    axil_req_t port_req [2];
    axil_rsp_t port_rsp [2];
    axil_req_t mem_req;
    axil_rsp_t mem_rsp;

    lsu_port lsu_port0 (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid[0]),
        .req_ready  (req_ready[0]),
        .req        (req[0]),
        .resp_valid (resp_valid[0]),
        .resp       (resp[0]),
        .bus_req    (port_req[0]),
        .bus_rsp    (port_rsp[0])
    );

    lsu_port lsu_port1 (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid[1]),
        .req_ready  (req_ready[1]),
        .req        (req[1]),
        .resp_valid (resp_valid[1]),
        .resp       (resp[1]),
        .bus_req    (port_req[1]),
        .bus_rsp    (port_rsp[1])
    );

    // one transaction at a time into the memory
    axil_arbiter arb0 (
        .clk   (clk),
        .reset (reset),
        .m_req (port_req),
        .m_rsp (port_rsp),
        .s_req (mem_req),
        .s_rsp (mem_rsp)
    );

    data_mem #(
        .mem_words (mem_words)
    ) mem0 (
        .clk     (clk),
        .reset   (reset),
        .bus_req (mem_req),
        .bus_rsp (mem_rsp)
    );

endmodule

// File: test/lsu_properties.sv
`timescale 1ns/100ps

module lsu_properties import axil_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      busy,
    input logic      grant,
    input axil_rsp_t m_rsp [2],
    input axil_req_t s_req,
    input axil_rsp_t s_rsp
);

    // any ready or response valid on one master link
    function automatic logic link_active(input axil_rsp_t r);
        return r.awready | r.wready | r.arready | r.bvalid | r.rvalid;
    endfunction

    slave_valid_busy: assert property (@(posedge clk) disable iff (reset)
        (s_req.arvalid || s_req.awvalid || s_req.wvalid) |-> busy)
        else $error("slave valid raised while no transaction is open");

    // grant only moves while the bus is idle
    grant_stable: assert property (@(posedge clk) disable iff (reset)
        busy |=> $stable(grant))
        else $error("grant changed during an open transaction");

    loser0_quiet: assert property (@(posedge clk) disable iff (reset)
        !(busy && grant == 1'b0) |-> !link_active(m_rsp[0]))
        else $error("master 0 saw a ready or response without the grant");

    loser1_quiet: assert property (@(posedge clk) disable iff (reset)
        !(busy && grant == 1'b1) |-> !link_active(m_rsp[1]))
        else $error("master 1 saw a ready or response without the grant");

    ar_hold: assert property (@(posedge clk) disable iff (reset)
        s_req.arvalid && !s_rsp.arready |=> s_req.arvalid)
        else $error("arvalid dropped before arready");

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        s_req.awvalid && !s_rsp.awready |=> s_req.awvalid)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge clk) disable iff (reset)
        s_req.wvalid && !s_rsp.wready |=> s_req.wvalid)
        else $error("wvalid dropped before wready");

endmodule

// File: test/tb_lsu_subsystem.sv
`timescale 1ns/100ps

module tb_lsu_subsystem
    import lsu_pkg::*;
();

    localparam int clk_period      = 40;
    localparam int mem_words       = 1024;
    localparam int mem_bytes       = 4 * mem_words;
    localparam int resp_limit      = 64;
    localparam int fill_ops        = 16;
    localparam int widths_ops      = 200;
    localparam int traffic_ops     = 150;
    localparam int cross_ops       = 8;
    localparam int error_ops       = 6;
    localparam int total_ops       = 2 + fill_ops + widths_ops + 2 * (fill_ops + traffic_ops)
                                     + 2 * cross_ops + error_ops;
    localparam int watchdog_cycles = 5 + total_ops * 20;

    logic       clk = 1'b0;
    logic       reset;
    logic [1:0] req_valid;
    logic [1:0] req_ready;
    lsu_req_t   req [2];
    logic [1:0] resp_valid;
    lsu_resp_t  resp [2];

    // byte-wide copy of the data memory
    logic [7:0]  model_mem [mem_bytes];
    logic [31:0] rng [2];
    int          done_ops [2];
    int          n_pass;
    int          n_fail;

    lsu_subsystem_top #(
        .mem_words (mem_words)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    bind axil_arbiter lsu_properties props0 (
        .clk   (clk),
        .reset (reset),
        .busy  (busy),
        .grant (grant),
        .m_rsp (m_rsp),
        .s_req (s_req),
        .s_rsp (s_rsp)
    );

    always #(clk_period / 2) clk = ~clk;

    // one generator per port keeps each stream independent of process order
    function automatic logic [31:0] next_random(input int p);
        logic [31:0] x;
        x = rng[p];
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng[p] = x;
        return x;
    endfunction

    // funct3[1:0] is log2 of the access size
    function automatic logic [31:0] aligned_addr(input logic [31:0] window,
                                                 input logic [5:0] off, input logic [2:0] f3);
        return window + ({26'b0, off} & ~((32'd1 << f3[1:0]) - 32'd1));
    endfunction

    function automatic void model_store(input logic [31:0] a, input logic [2:0] f3,
                                        input logic [31:0] data);
        logic [31:0] ai;
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            ai = a + 32'(i);
            model_mem[ai % mem_bytes] = data[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] model_load(input logic [31:0] a, input logic [2:0] f3);
        logic [31:0] ai;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            ai = a + 32'(i);
            v[8*i +: 8] = model_mem[ai % mem_bytes];
        end
        // LB and LH copy the top bit upward, LBU and LHU leave zeros
        case (f3)
            f3_b:    v = {{24{v[7]}}, v[7:0]};
            f3_h:    v = {{16{v[15]}}, v[15:0]};
            default: v = v;
        endcase
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // present one request, wait for acceptance and then for the response pulse
    task automatic run_op(input int p, input logic [31:0] inst, input logic [31:0] base,
                          input logic [31:0] sdata, output lsu_resp_t r, output logic got);
        int waited;
        req[p].inst       = inst;
        req[p].base       = base;
        req[p].store_data = sdata;
        req_valid[p]      = 1'b1;
        do @(negedge clk); while (!req_ready[p]);
        @(posedge clk);
        #2;
        req_valid[p] = 1'b0;
        got    = 1'b0;
        waited = 0;
        r      = '0;
        while (!got && waited < resp_limit) begin
            @(negedge clk);
            if (resp_valid[p]) begin
                got = 1'b1;
                r   = resp[p];
            end
            waited++;
        end
        assert (got) begin
            done_ops[p]++;
        end else begin
            n_fail++;
            $display("port %0d gave no response within %0d cycles at %0t", p, resp_limit, $time);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic exec_op(input int p, input logic st, input logic [2:0] f3,
                           input logic [31:0] addr, input logic [31:0] data);
        logic [11:0] imm;
        logic [31:0] inst;
        lsu_resp_t   r;
        logic        got;
        imm = 12'(next_random(p));
        if (st) begin
            inst = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], op_store};
        end else begin
            inst = {imm, 5'd1, f3, 5'd3, op_load};
        end
        run_op(p, inst, addr - {{20{imm[11]}}, imm}, data, r, got);
        if (got) begin
            check_value($sformatf("port%0d resp.err", p), 32'd0, 32'(r.err));
            check_value($sformatf("port%0d resp.load", p), 32'(!st), 32'(r.load));
            if (st) begin
                model_store(addr, f3, data);
            end else begin
                check_value($sformatf("port%0d resp.data", p), model_load(addr, f3), r.data);
            end
        end
    endtask

    task automatic error_op(input int p, input logic [31:0] inst, input logic [31:0] base,
                            input string what);
        lsu_resp_t r;
        logic      got;
        run_op(p, inst, base, next_random(p), r, got);
        if (got) begin
            check_value($sformatf("port%0d resp.err (%s)", p, what), 32'd1, 32'(r.err));
        end
    endtask

    task automatic random_traffic(input int p, input logic [31:0] window, input int count);
        logic [31:0] r;
        logic [2:0]  f3;
        logic        st;
        // write every word of the window before any load
        for (int i = 0; i < fill_ops; i++) begin
            exec_op(p, 1'b1, f3_w, window + 32'(4 * i), next_random(p));
        end
        for (int i = 0; i < count; i++) begin
            r = next_random(p);
            case (r[2:0])
                3'd0:    {st, f3} = {1'b1, f3_b};
                3'd1:    {st, f3} = {1'b1, f3_h};
                3'd2:    {st, f3} = {1'b1, f3_w};
                3'd3:    {st, f3} = {1'b0, f3_b};
                3'd4:    {st, f3} = {1'b0, f3_h};
                3'd5:    {st, f3} = {1'b0, f3_w};
                3'd6:    {st, f3} = {1'b0, f3_bu};
                default: {st, f3} = {1'b0, f3_hu};
            endcase
            exec_op(p, st, f3, aligned_addr(window, r[13:8], f3), next_random(p));
        end
    endtask

    task automatic finish_test(input int num, input string title, input int ps, input int fs);
        $display("test %0d %s: %0d checks, %0d failed", num, title,
                 (n_pass + n_fail) - (ps + fs), n_fail - fs);
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int          ps;
        int          fs;
        logic [31:0] r;
        logic [31:0] w;
        logic [2:0]  f3;
        reset       = 1'b1;
        req_valid   = '0;
        req[0]      = '0;
        req[1]      = '0;
        n_pass      = 0;
        n_fail      = 0;
        done_ops[0] = 0;
        done_ops[1] = 0;
        rng[0]      = 32'h5ac9_1790;
        rng[1]      = next_random(0);
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        ps = n_pass;
        fs = n_fail;
        check_value("req_ready", 32'(2'b11), 32'(req_ready));
        check_value("resp_valid", 32'd0, 32'(resp_valid));
        exec_op(0, 1'b1, f3_w, 32'h0000_0100, next_random(0));
        exec_op(0, 1'b0, f3_w, 32'h0000_0100, 32'h0);
        finish_test(1, "after reset", ps, fs);

        ps = n_pass;
        fs = n_fail;
        random_traffic(0, 32'h0000_0040, widths_ops);
        finish_test(2, "all widths on port 0", ps, fs);

        ps = n_pass;
        fs = n_fail;
        done_ops[0] = 0;
        done_ops[1] = 0;
        // lower half for port 0, upper half for port 1
        fork
            random_traffic(0, 32'h0000_0200, traffic_ops);
            random_traffic(1, 32'h0000_0a00, traffic_ops);
        join
        check_value("port0 completed ops", 32'(fill_ops + traffic_ops), 32'(done_ops[0]));
        check_value("port1 completed ops", 32'(fill_ops + traffic_ops), 32'(done_ops[1]));
        finish_test(3, "concurrent traffic", ps, fs);

        ps = n_pass;
        fs = n_fail;
        for (int k = 0; k < cross_ops; k++) begin
            r  = next_random(0);
            f3 = (r[1:0] == 2'd0) ? f3_b : (r[1:0] == 2'd1) ? f3_h : f3_w;
            w  = aligned_addr(32'h0000_0300, r[13:8], f3);
            exec_op(0, 1'b1, f3, w, next_random(0));
            if (f3 != f3_w) begin
                f3 = {r[4], f3[1:0]};
            end
            exec_op(1, 1'b0, f3, w, 32'h0);
        end
        finish_test(4, "cross-port visibility", ps, fs);

        ps = n_pass;
        fs = n_fail;
        w  = 32'h0000_0040;
        error_op(0, {12'h000, 5'd1, f3_h, 5'd3, op_load}, w + 32'd1, "misaligned LH");
        error_op(0, {12'h000, 5'd1, f3_w, 5'd3, op_load}, w + 32'd2, "misaligned LW");
        error_op(0, {7'h00, 5'd2, 5'd1, f3_h, 5'd0, op_store}, w + 32'd3, "misaligned SH");
        error_op(0, {7'h00, 5'd2, 5'd1, f3_w, 5'd0, op_store}, w + 32'd1, "misaligned SW");
        error_op(0, {12'h000, 5'd1, f3_w, 5'd3, 7'b0110011}, w, "non-memory opcode");
        exec_op(0, 1'b0, f3_w, w, 32'h0);
        finish_test(5, "error path", ps, fs);

        $display("summary: %0d checks passed, %0d checks failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/axil_pkg.sv
rtl/lsu_pkg.sv
rtl/lsu_port.sv
rtl/axil_arbiter.sv
rtl/data_mem.sv
rtl/lsu_subsystem_top.sv
test/lsu_properties.sv
test/tb_lsu_subsystem.sv
